// File: design/main_cu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, opcodes and types of the main control unit
// Import with main_cu_pkg::* in the module header where needed
// Holds the TLB flush command encoding and the instruction union
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package main_cu_pkg;

	// Datapath widths
	localparam int ILEN     = 32;
	localparam int XLEN     = 64;
	localparam int ASID_LEN = 16;

	// Sv39 virtual page number from VA bits 38..12
	localparam int VPN_LEN  = 27;
	localparam int VPN_LSB  = 12;
	localparam int VPN_MSB  = VPN_LSB + VPN_LEN - 1;

	// Instruction field widths
	localparam int OPCODE_LEN   = 7;
	localparam int FUNCT3_LEN   = 3;
	localparam int FUNCT7_LEN   = 7;
	localparam int REG_ADDR_LEN = 5;

	// Major opcodes
	localparam logic [OPCODE_LEN-1:0] OPCODE_MISC_MEM = 7'b0001111;
	localparam logic [OPCODE_LEN-1:0] OPCODE_SYSTEM   = 7'b1110011;
	// Ordinary traffic that needs no maintenance
	localparam logic [OPCODE_LEN-1:0] OPCODE_BRANCH   = 7'b1100011;
	localparam logic [OPCODE_LEN-1:0] OPCODE_LOAD     = 7'b0000011;

	// Minor opcodes for the two system instructions
	localparam logic [FUNCT3_LEN-1:0] FUNCT3_FENCE_I    = 3'b001;
	localparam logic [FUNCT3_LEN-1:0] FUNCT3_PRIV       = 3'b000;
	localparam logic [FUNCT7_LEN-1:0] FUNCT7_SFENCE_VMA = 7'b0001001;

	// TLB flush command shared by L1 and L2 TLB
	typedef enum logic [2:0] {
		NoFlush       = 3'd0,
		FlushAll      = 3'd1,
		FlushAsid     = 3'd2,
		FlushPage     = 3'd3,
		FlushAsidPage = 3'd4
	} tlb_flush_e;

	// I-type layout as used by FENCE / FENCE.I
	typedef struct packed {
		logic [3:0]              fm;
		logic [3:0]              pred;
		logic [3:0]              succ;
		logic [REG_ADDR_LEN-1:0] rs1;
		logic [FUNCT3_LEN-1:0]   funct3;
		logic [REG_ADDR_LEN-1:0] rd;
		logic [OPCODE_LEN-1:0]   opcode;
	} fence_instr_t;

	// R-type layout as used by SFENCE.VMA
	typedef struct packed {
		logic [FUNCT7_LEN-1:0]   funct7;
		logic [REG_ADDR_LEN-1:0] rs2;
		logic [REG_ADDR_LEN-1:0] rs1;
		logic [FUNCT3_LEN-1:0]   funct3;
		logic [REG_ADDR_LEN-1:0] rd;
		logic [OPCODE_LEN-1:0]   opcode;
	} rtype_instr_t;

	// One word with two decodings
	typedef union packed {
		fence_instr_t fence;
		rtype_instr_t rtype;
	} instr_u;

endpackage

// File: design/sys_instr_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational decode of FENCE.I and SFENCE.VMA
// Also gives the TLB flush type from the rs1/rs2 register fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module sys_instr_decoder
	import main_cu_pkg::*;
(
	input  logic [ILEN-1:0] ins_i,

	output logic            is_fence_i_o,
	output logic            is_sfence_vma_o,
	output tlb_flush_e      flush_type_o
);

	instr_u ins;
	logic   rs1_zero;
	logic   rs2_zero;

	// Same bits seen through either view below
	assign ins = ins_i;

	// FENCE.I only needs opcode and funct3
	// fm/pred/succ are ignored on purpose
	assign is_fence_i_o = (ins.fence.opcode == OPCODE_MISC_MEM) &&
	                      (ins.fence.funct3 == FUNCT3_FENCE_I);

	// SFENCE.VMA needs rd at x0
	assign is_sfence_vma_o = (ins.rtype.opcode == OPCODE_SYSTEM) &&
	                         (ins.rtype.funct3 == FUNCT3_PRIV) &&
	                         (ins.rtype.funct7 == FUNCT7_SFENCE_VMA) &&
	                         (ins.rtype.rd == '0);

	// x0 checks look at register fields rather than operand values
	assign rs1_zero = (ins.rtype.rs1 == '0);
	assign rs2_zero = (ins.rtype.rs2 == '0);

	// Flush scope
	always_comb begin
		flush_type_o = NoFlush;
		if (is_sfence_vma_o) begin
			unique case ({rs1_zero, rs2_zero})
				// No address and no ASID flushes everything
				2'b11: flush_type_o = FlushAll;
				// ASID only
				2'b10: flush_type_o = FlushAsid;
				// Page in every address space
				2'b01: flush_type_o = FlushPage;
				// Page in one address space
				default: flush_type_o = FlushAsidPage;
			endcase
		end
	end

endmodule

// File: design/mem_maint_seq.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory maintenance sequencer for FENCE.I and SFENCE.VMA
// Started by a one-cycle pulse, answers with a one-cycle done
// FENCE.I syncs L1D to L2 until L2 done, then flushes memory
// SFENCE.VMA aborts and clears MSHRs, then sends one TLB flush
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module mem_maint_seq
	import main_cu_pkg::*;
(
	input  logic                clk_i,
	input  logic                rst_n_i,

	// Start pulses from the control FSM
	input  logic                start_fence_i_i,
	input  logic                start_sfence_i,
	input  tlb_flush_e          flush_type_i,
	input  logic [XLEN-1:0]     rs1_data_i,
	input  logic [XLEN-1:0]     rs2_data_i,

	// Level from L2 that only matters during SYNC
	input  logic                l2c_update_done_i,

	output logic                done_o,

	// Memory system strobes
	output logic                mem_flush_o,
	output logic                mem_abort_o,
	output logic                mem_clr_l1tlb_mshr_o,
	output logic                mem_clr_l2tlb_mshr_o,
	output logic                mem_clear_dmshr_dregs_o,
	output logic                mem_synch_l1dc_l2c_o,

	// TLB flush command
	output tlb_flush_e          mem_l1tlb_flush_type_o,
	output tlb_flush_e          mem_l2tlb_flush_type_o,
	output logic [ASID_LEN-1:0] mem_flush_asid_o,
	output logic [VPN_LEN-1:0]  mem_flush_page_o
);

	typedef enum logic [2:0] {
		IDLE,
		SYNC,
		FLUSH,
		ABORT,
		TLBFL
	} seq_state_e;

	seq_state_e          state_q;
	seq_state_e          state_d;

	// Command captured at start
	tlb_flush_e          flush_type_q;
	logic [ASID_LEN-1:0] asid_q;
	logic [VPN_LEN-1:0]  page_q;

	// State register
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Payload captured on the SFENCE.VMA start pulse
	always_ff @(posedge clk_i) begin
		if (start_sfence_i) begin
			flush_type_q <= flush_type_i;
			// ASID from rs2, VPN from the rs1 virtual address
			asid_q       <= rs2_data_i[ASID_LEN-1:0];
			page_q       <= rs1_data_i[VPN_MSB:VPN_LSB];
		end
	end

	// Next state
	always_comb begin
		state_d = state_q;
		unique case (state_q)
			IDLE: begin
				if (start_fence_i_i) begin
					state_d = SYNC;
				end else if (start_sfence_i) begin
					state_d = ABORT;
				end
			end
			// Hold sync until L2 confirms write-back
			SYNC: begin
				if (l2c_update_done_i) begin
					state_d = FLUSH;
				end
			end
			FLUSH: state_d = IDLE;
			ABORT: state_d = TLBFL;
			TLBFL: state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	// Moore outputs with one step per state
	assign mem_synch_l1dc_l2c_o    = (state_q == SYNC);
	assign mem_flush_o             = (state_q == FLUSH);

	// Abort and all MSHR clears go together
	assign mem_abort_o             = (state_q == ABORT);
	assign mem_clr_l1tlb_mshr_o    = (state_q == ABORT);
	assign mem_clr_l2tlb_mshr_o    = (state_q == ABORT);
	assign mem_clear_dmshr_dregs_o = (state_q == ABORT);

	// Same command to both TLB levels and zero outside TLBFL
	assign mem_l1tlb_flush_type_o  = (state_q == TLBFL) ? flush_type_q : NoFlush;
	assign mem_l2tlb_flush_type_o  = (state_q == TLBFL) ? flush_type_q : NoFlush;
	assign mem_flush_asid_o        = (state_q == TLBFL) ? asid_q : '0;
	assign mem_flush_page_o        = (state_q == TLBFL) ? page_q : '0;

	// Last step of either sequence
	assign done_o = (state_q == FLUSH) || (state_q == TLBFL);

endmodule

// File: design/main_cu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Main control unit of the core
// Accepts front-end instructions, handles exceptions and
// launches FENCE.I / SFENCE.VMA memory maintenance
// Stall and flush outputs go to the rest of the pipeline
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module main_cu
	import main_cu_pkg::*;
(
	input  logic                clk_i,
	input  logic                rst_n_i,

	// Front end
	input  logic                fe_valid_i,
	input  logic [ILEN-1:0]     fe_ins_i,
	input  logic                fe_except_raised_i,

	// Back end
	input  logic                be_stall_i,
	input  logic                be_flush_i,
	input  logic [XLEN-1:0]     be_rs1_data_i,
	input  logic [XLEN-1:0]     be_rs2_data_i,

	// Pipeline control
	output logic                stall_o,
	output logic                flush_o,

	// Memory system
	input  logic                mem_l2c_update_done_i,
	output logic                mem_flush_o,
	output logic                mem_abort_o,
	output logic                mem_clr_l1tlb_mshr_o,
	output logic                mem_clr_l2tlb_mshr_o,
	output logic                mem_clear_dmshr_dregs_o,
	output logic                mem_synch_l1dc_l2c_o,
	output tlb_flush_e          mem_l1tlb_flush_type_o,
	output tlb_flush_e          mem_l2tlb_flush_type_o,
	output logic [ASID_LEN-1:0] mem_flush_asid_o,
	output logic [VPN_LEN-1:0]  mem_flush_page_o
);

	typedef enum logic [1:0] {
		RESET,
		RUN,
		EXCEPT,
		MAINT
	} cu_state_e;

	cu_state_e  state_q;
	cu_state_e  state_d;

	logic       accept;
	logic       is_fence_i;
	logic       is_sfence_vma;
	tlb_flush_e flush_type;
	logic       start_fence_i;
	logic       start_sfence;
	logic       except_flush_q;
	logic       seq_done;

	sys_instr_decoder u_dec (
		.ins_i           (fe_ins_i),
		.is_fence_i_o    (is_fence_i),
		.is_sfence_vma_o (is_sfence_vma),
		.flush_type_o    (flush_type)
	);

	// Pipeline stalls in every state other than RUN and RESET
	assign stall_o = (state_q != RUN) && (state_q != RESET);

	// Instruction taken this cycle
	assign accept = fe_valid_i && !stall_o && !be_stall_i && (state_q == RUN);

	// Exception wins over decode
	assign start_fence_i = accept && !fe_except_raised_i && is_fence_i;
	assign start_sfence  = accept && !fe_except_raised_i && is_sfence_vma;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= RESET;
		end else begin
			state_q <= state_d;
		end
	end

	// Control FSM
	always_comb begin
		state_d = state_q;
		unique case (state_q)
			// Single cycle after reset
			RESET: state_d = RUN;
			RUN: begin
				if (accept && fe_except_raised_i) begin
					state_d = EXCEPT;
				end else if (start_fence_i || start_sfence) begin
					state_d = MAINT;
				end
			end
			// One stall cycle while the flush goes out
			EXCEPT: state_d = RUN;
			// Sequence always runs to completion
			MAINT: begin
				if (seq_done) begin
					state_d = RUN;
				end
			end
			default: state_d = RUN;
		endcase
	end

	// Exception flush lands on T+1
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			except_flush_q <= 1'b0;
		end else begin
			except_flush_q <= accept && fe_except_raised_i;
		end
	end

	// Back-end flush passes straight through
	assign flush_o = except_flush_q || be_flush_i;

	mem_maint_seq u_seq (
		.clk_i                   (clk_i),
		.rst_n_i                 (rst_n_i),
		.start_fence_i_i         (start_fence_i),
		.start_sfence_i          (start_sfence),
		.flush_type_i            (flush_type),
		.rs1_data_i              (be_rs1_data_i),
		.rs2_data_i              (be_rs2_data_i),
		.l2c_update_done_i       (mem_l2c_update_done_i),
		.done_o                  (seq_done),
		.mem_flush_o             (mem_flush_o),
		.mem_abort_o             (mem_abort_o),
		.mem_clr_l1tlb_mshr_o    (mem_clr_l1tlb_mshr_o),
		.mem_clr_l2tlb_mshr_o    (mem_clr_l2tlb_mshr_o),
		.mem_clear_dmshr_dregs_o (mem_clear_dmshr_dregs_o),
		.mem_synch_l1dc_l2c_o    (mem_synch_l1dc_l2c_o),
		.mem_l1tlb_flush_type_o  (mem_l1tlb_flush_type_o),
		.mem_l2tlb_flush_type_o  (mem_l2tlb_flush_type_o),
		.mem_flush_asid_o        (mem_flush_asid_o),
		.mem_flush_page_o        (mem_flush_page_o)
	);

endmodule

// File: testbench/main_cu_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output timing assertions bound into every main_cu instance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module main_cu_assert
	import main_cu_pkg::*;
(
	input logic       clk_i,
	input logic       rst_n_i,
	input logic       stall_o,
	input logic       mem_flush_o,
	input logic       mem_abort_o,
	input logic       mem_clr_l1tlb_mshr_o,
	input logic       mem_clr_l2tlb_mshr_o,
	input logic       mem_clear_dmshr_dregs_o,
	input logic       mem_synch_l1dc_l2c_o,
	input tlb_flush_e mem_l1tlb_flush_type_o,
	input tlb_flush_e mem_l2tlb_flush_type_o
);

	logic any_strobe;

	assign any_strobe = mem_flush_o || mem_abort_o || mem_clr_l1tlb_mshr_o ||
	                    mem_clr_l2tlb_mshr_o || mem_clear_dmshr_dregs_o || mem_synch_l1dc_l2c_o;

	// Memory flush lasts one cycle
	flush_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		mem_flush_o |=> !mem_flush_o)
		else $error("mem_flush_o longer than one cycle");

	// Pipeline held during any maintenance step
	stall_cover: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		any_strobe |-> stall_o)
		else $error("memory strobe without stall_o");

	// TLB command only right after the MSHR clear
	tlb_after_clr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!$past(mem_clr_l1tlb_mshr_o) |->
		(mem_l1tlb_flush_type_o == NoFlush && mem_l2tlb_flush_type_o == NoFlush))
		else $error("TLB flush type outside its slot");

endmodule

bind main_cu main_cu_assert u_assert (.*);

// File: testbench/main_cu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the main control unit
// Runs FENCE.I, SFENCE.VMA, exception, ordinary and back-end tests
// Prints one line per test and a closing count line
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module main_cu_tb
	import main_cu_pkg::*;
;

	localparam int PERIOD       = 40;
	localparam int RST_CYCLES   = 4;
	localparam int MAX_L2_DELAY = 10;
	// Rough cycle budget of each test
	localparam int FENCE_LEN    = 6 + MAX_L2_DELAY;
	localparam int SFENCE_LEN   = 6;
	localparam int N_ORD        = 8;
	localparam int RUN_CYCLES   = RST_CYCLES + 4 * FENCE_LEN + 4 * SFENCE_LEN + 6
	                              + N_ORD + 4 + 8;
	localparam int LIMIT_NS     = (RUN_CYCLES + MAX_L2_DELAY) * 4 * PERIOD;

	logic                clk_i;
	logic                rst_n_i;
	logic                fe_valid_i;
	logic [ILEN-1:0]     fe_ins_i;
	logic                fe_except_raised_i;
	logic                be_stall_i;
	logic                be_flush_i;
	logic [XLEN-1:0]     be_rs1_data_i;
	logic [XLEN-1:0]     be_rs2_data_i;
	logic                mem_l2c_update_done_i;
	logic                stall_o;
	logic                flush_o;
	logic                mem_flush_o;
	logic                mem_abort_o;
	logic                mem_clr_l1tlb_mshr_o;
	logic                mem_clr_l2tlb_mshr_o;
	logic                mem_clear_dmshr_dregs_o;
	logic                mem_synch_l1dc_l2c_o;
	tlb_flush_e          mem_l1tlb_flush_type_o;
	tlb_flush_e          mem_l2tlb_flush_type_o;
	logic [ASID_LEN-1:0] mem_flush_asid_o;
	logic [VPN_LEN-1:0]  mem_flush_page_o;

	integer seed;
	int     errors;
	int     checks;
	int     tests;

	// Strobe counters written by the monitor
	int cnt_sync;
	int cnt_mflush;
	int cnt_abort;
	// Cycles with all three clears high
	int cnt_clr;
	// Cycles with any clear high
	int cnt_clr_any;
	int cnt_tlb;
	int cnt_stall;
	int cnt_flush;
	int cnt_mem;
	// Last flush command seen
	tlb_flush_e          lat_type1;
	tlb_flush_e          lat_type2;
	logic [ASID_LEN-1:0] lat_asid;
	logic [VPN_LEN-1:0]  lat_page;

	main_cu dut0 (.*);

	initial begin
		clk_i = 1'b0;
		forever #(PERIOD / 2) clk_i = ~clk_i;
	end

	// Expected TLB command from the register fields and operand values
	function automatic void exp_tlb_cmd(input logic [31:0] ins, input logic [63:0] rs1,
	                                    input logic [63:0] rs2, output tlb_flush_e t,
	                                    output logic [15:0] asid, output logic [26:0] page);
		logic rs1_x0;
		logic rs2_x0;
		rs1_x0 = (ins[19:15] == 5'd0);
		rs2_x0 = (ins[24:20] == 5'd0);
		if (rs1_x0 && rs2_x0) t = FlushAll;
		else if (rs1_x0) t = FlushAsid;
		else if (rs2_x0) t = FlushPage;
		else t = FlushAsidPage;
		asid = rs2[15:0];
		// Sv39 VPN is VA 38..12
		page = rs1[38:12];
	endfunction

	function automatic logic [31:0] fence_i_word();
		instr_u w;
		w = '0;
		w.fence.opcode = OPCODE_MISC_MEM;
		w.fence.funct3 = FUNCT3_FENCE_I;
		return w;
	endfunction

	function automatic logic [31:0] sfence_word(input logic [4:0] rs1, input logic [4:0] rs2);
		instr_u w;
		w = '0;
		w.rtype.opcode = OPCODE_SYSTEM;
		w.rtype.funct3 = FUNCT3_PRIV;
		w.rtype.funct7 = FUNCT7_SFENCE_VMA;
		w.rtype.rs1    = rs1;
		w.rtype.rs2    = rs2;
		return w;
	endfunction

	// Monitor samples at the falling edge where outputs are settled
	always @(negedge clk_i) begin
		if (rst_n_i) begin
			if (mem_synch_l1dc_l2c_o) cnt_sync++;
			if (mem_flush_o) cnt_mflush++;
			if (mem_abort_o) cnt_abort++;
			if (mem_clr_l1tlb_mshr_o && mem_clr_l2tlb_mshr_o && mem_clear_dmshr_dregs_o)
				cnt_clr++;
			if (mem_clr_l1tlb_mshr_o || mem_clr_l2tlb_mshr_o || mem_clear_dmshr_dregs_o)
				cnt_clr_any++;
			if (stall_o) cnt_stall++;
			if (flush_o) cnt_flush++;
			if (mem_flush_o || mem_abort_o || mem_clr_l1tlb_mshr_o || mem_clr_l2tlb_mshr_o ||
			    mem_clear_dmshr_dregs_o || mem_synch_l1dc_l2c_o)
				cnt_mem++;
			if (mem_l1tlb_flush_type_o != NoFlush || mem_l2tlb_flush_type_o != NoFlush) begin
				cnt_tlb++;
				lat_type1 = mem_l1tlb_flush_type_o;
				lat_type2 = mem_l2tlb_flush_type_o;
				lat_asid  = mem_flush_asid_o;
				lat_page  = mem_flush_page_o;
			end
		end
	end

	task automatic check(input string name, input string what, input longint unsigned exp,
	                     input longint unsigned act);
		checks++;
		if (exp != act) begin
			errors++;
			$display("FAILED %s %s expected %0h actual %0h", name, what, exp, act);
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		tests++;
		if (errors == err_before) $display("ok    %s", name);
		else $display("bad   %s (%0d wrong)", name, errors - err_before);
	endtask

	// FENCE.I test that can first be held off by be_stall_i
	task automatic run_fence(input string name, input int delay, input int hold);
		int e0;
		int sync0;
		int mfl0;
		int st0;
		int waited;
		e0    = errors;
		sync0 = cnt_sync;
		mfl0  = cnt_mflush;
		@(posedge clk_i);
		fe_valid_i <= 1'b1;
		fe_ins_i   <= fence_i_word();
		be_stall_i <= (hold != 0);
		for (int i = 0; i < hold; i++) begin
			@(negedge clk_i);
			check(name, "sync under be_stall", 0, mem_synch_l1dc_l2c_o);
			@(posedge clk_i);
			if (i == hold - 1) be_stall_i <= 1'b0;
		end
		if (hold != 0) begin
			check(name, "syncs before accept", sync0, cnt_sync);
		end
		// Accepting cycle T
		@(negedge clk_i);
		st0 = cnt_stall;
		for (int i = 1; i <= delay; i++) begin
			@(posedge clk_i);
			if (i == 1) fe_valid_i <= 1'b0;
			if (i == delay) mem_l2c_update_done_i <= 1'b1;
		end
		waited = 0;
		do begin
			@(negedge clk_i);
			waited++;
		end while (!mem_flush_o && waited < 20);
		if (!mem_flush_o) begin
			errors++;
			$display("%s: mem_flush_o never pulsed after the L2 done", name);
		end
		@(posedge clk_i);
		mem_l2c_update_done_i <= 1'b0;
		@(negedge clk_i);
		check(name, "sync cycles", delay, cnt_sync - sync0);
		check(name, "mem_flush pulses", 1, cnt_mflush - mfl0);
		check(name, "stall cycles", delay + 1, cnt_stall - st0);
		check(name, "stall after end", 0, stall_o);
		end_test(name, e0);
	endtask

	task automatic run_sfence(input string name, input bit rs1_x0, input bit rs2_x0);
		int                  e0;
		int                  ab0;
		int                  clr0;
		int                  clra0;
		int                  tlb0;
		int                  st0;
		int                  waited;
		logic [31:0]         r;
		logic [4:0]          f1;
		logic [4:0]          f2;
		logic [31:0]         ins;
		logic [63:0]         op1;
		logic [63:0]         op2;
		tlb_flush_e          et;
		logic [ASID_LEN-1:0] ea;
		logic [VPN_LEN-1:0]  ep;
		e0    = errors;
		ab0   = cnt_abort;
		clr0  = cnt_clr;
		clra0 = cnt_clr_any;
		tlb0  = cnt_tlb;
		r     = $random(seed);
		f1    = rs1_x0 ? 5'd0 : ((r[4:0] == 5'd0) ? 5'd7 : r[4:0]);
		f2    = rs2_x0 ? 5'd0 : ((r[9:5] == 5'd0) ? 5'd11 : r[9:5]);
		ins   = sfence_word(f1, f2);
		op1   = {$random(seed), $random(seed)};
		op2   = {$random(seed), $random(seed)};
		exp_tlb_cmd(ins, op1, op2, et, ea, ep);
		@(posedge clk_i);
		fe_valid_i    <= 1'b1;
		fe_ins_i      <= ins;
		be_rs1_data_i <= op1;
		be_rs2_data_i <= op2;
		@(negedge clk_i);
		st0 = cnt_stall;
		@(posedge clk_i);
		fe_valid_i <= 1'b0;
		waited = 0;
		do begin
			@(negedge clk_i);
			waited++;
		end while (cnt_tlb == tlb0 && waited < 8);
		@(negedge clk_i);
		check(name, "abort pulses", 1, cnt_abort - ab0);
		check(name, "mshr clear pulses", 1, cnt_clr - clr0);
		check(name, "mshr clear cycles", 1, cnt_clr_any - clra0);
		check(name, "tlb commands", 1, cnt_tlb - tlb0);
		check(name, "l1tlb type", et, lat_type1);
		check(name, "l2tlb type", et, lat_type2);
		check(name, "asid", ea, lat_asid);
		check(name, "page", ep, lat_page);
		check(name, "stall cycles", 2, cnt_stall - st0);
		end_test(name, e0);
	endtask

	initial begin
		int e0;
		int fl0;
		int st0;
		int mem0;
		int tlb0;
		logic [31:0] r;
		seed                  = 32'h5443_0543;
		errors                = 0;
		checks                = 0;
		tests                 = 0;
		rst_n_i               = 1'b0;
		fe_valid_i            = 1'b0;
		fe_ins_i              = '0;
		fe_except_raised_i    = 1'b0;
		be_stall_i            = 1'b0;
		be_flush_i            = 1'b0;
		be_rs1_data_i         = '0;
		be_rs2_data_i         = '0;
		mem_l2c_update_done_i = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_i);
		rst_n_i <= 1'b1;
		repeat (2) @(posedge clk_i);

		for (int i = 0; i < 3; i++) begin
			r = $random(seed);
			run_fence($sformatf("fence_i_%0d", i), 1 + int'(r[7:0]) % MAX_L2_DELAY, 0);
		end

		run_sfence("sfence_all", 1'b1, 1'b1);
		run_sfence("sfence_asid", 1'b1, 1'b0);
		run_sfence("sfence_page", 1'b0, 1'b1);
		run_sfence("sfence_asid_page", 1'b0, 1'b0);

		// Exception on a FENCE.I word starts no sync
		e0   = errors;
		fl0  = cnt_flush;
		mem0 = cnt_mem;
		@(posedge clk_i);
		fe_valid_i         <= 1'b1;
		fe_ins_i           <= fence_i_word();
		fe_except_raised_i <= 1'b1;
		@(negedge clk_i);
		st0 = cnt_stall;
		@(posedge clk_i);
		fe_valid_i         <= 1'b0;
		fe_except_raised_i <= 1'b0;
		repeat (3) @(negedge clk_i);
		check("exception", "flush pulses", 1, cnt_flush - fl0);
		check("exception", "stall cycles", 1, cnt_stall - st0);
		check("exception", "mem strobes", 0, cnt_mem - mem0);
		end_test("exception", e0);

		// Back-to-back ordinary traffic
		e0   = errors;
		st0  = cnt_stall;
		mem0 = cnt_mem;
		tlb0 = cnt_tlb;
		for (int i = 0; i < N_ORD; i++) begin
			r = $random(seed);
			@(posedge clk_i);
			fe_valid_i <= 1'b1;
			fe_ins_i   <= {r[31:7], r[0] ? OPCODE_BRANCH : OPCODE_LOAD};
		end
		@(posedge clk_i);
		fe_valid_i <= 1'b0;
		repeat (3) @(negedge clk_i);
		check("ordinary", "stall cycles", 0, cnt_stall - st0);
		check("ordinary", "mem strobes", 0, cnt_mem - mem0);
		check("ordinary", "tlb commands", 0, cnt_tlb - tlb0);
		end_test("ordinary", e0);

		// Back-end flush is combinational
		e0 = errors;
		@(posedge clk_i);
		be_flush_i <= 1'b1;
		@(negedge clk_i);
		check("be_flush", "flush_o high", 1, flush_o);
		@(posedge clk_i);
		be_flush_i <= 1'b0;
		@(negedge clk_i);
		check("be_flush", "flush_o low", 0, flush_o);
		end_test("be_flush", e0);

		run_fence("fence_i_be_stall", 4, 3);

		$display("tests %0d  checks %0d  errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(LIMIT_NS);
		$display("Run timed out after %0d ns, tests did not complete", LIMIT_NS);
		$display("Errors found");
		$finish;
	end

endmodule

// File: sim.f
design/main_cu_pkg.sv
design/sys_instr_decoder.sv
design/mem_maint_seq.sv
design/main_cu.sv
testbench/main_cu_assert.sv
testbench/main_cu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the main_cu testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module main_cu_tb \
	-f sim.f

./obj_dir/Vmain_cu_tb | tee sim.log

if grep -qx "No errors" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
